// ==== flist.f ====
+incdir+tests
rtl/streamer_pkg.sv
rtl/tcdm_pkg.sv
rtl/stream_addr_gen.sv
rtl/stream_source.sv
rtl/stream_sink.sv
rtl/tcdm_port_arbiter.sv
rtl/streamer_top.sv
tests/tb_streamer.sv

// ==== rtl/stream_addr_gen.sv ====
/* Base-plus-stride address sequencer with word counter and busy state */
`timescale 1ns/1ps

module stream_addr_gen
  import streamer_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  stream_cfg_t       cfg_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic              valid_o,
  input  logic              accept_i,
  output logic              last_o,
  output logic              busy_o
);

  agen_state_e       state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [15:0]       stride_q;
  logic [15:0]       remain_q;

  // A zero word count never leaves idle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= AGEN_IDLE;
      remain_q <= '0;
    end else begin
      case (state_q)
        AGEN_IDLE: begin
          if (cfg_i.start && (cfg_i.count != '0)) begin
            state_q  <= AGEN_RUN;
            remain_q <= cfg_i.count;
          end
        end
        AGEN_RUN: begin
          if (accept_i) begin
            remain_q <= remain_q - 16'd1;
            if (remain_q == 16'd1) begin
              state_q <= AGEN_IDLE;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == AGEN_IDLE) && cfg_i.start) begin
      addr_q   <= cfg_i.base;
      stride_q <= cfg_i.stride;
    end else if (valid_o && accept_i) begin
      addr_q <= addr_q + ADDR_W'(stride_q);
    end
  end

  assign addr_o  = addr_q;
  assign valid_o = (state_q == AGEN_RUN);
  assign last_o  = valid_o && (remain_q == 16'd1);
  assign busy_o  = (state_q == AGEN_RUN);

endmodule

// ==== rtl/stream_sink.sv ====
/* Store stream: incoming Z stream, two-entry store FIFO, address
   generator and write requests */
`timescale 1ns/1ps

module stream_sink
  import streamer_pkg::*;
  import tcdm_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  stream_cfg_t       cfg_i,
  input  logic              stream_valid_i,
  input  logic [DATA_W-1:0] stream_data_i,
  output logic              stream_ready_o,
  output tcdm_req_t         req_o,
  input  logic              gnt_i,
  output logic              busy_o
);

  logic [ADDR_W-1:0] agen_addr;
  logic              agen_valid;
  logic              agen_busy;
  logic [DATA_W-1:0] fifo_q [2];
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [1:0]        cnt_q;
  logic              push;
  logic              pop;

  stream_addr_gen i_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .cfg_i    ( cfg_i      ),
    .addr_o   ( agen_addr  ),
    .valid_o  ( agen_valid ),
    .accept_i ( pop        ),
    .last_o   (            ),
    .busy_o   ( agen_busy  )
  );

  // Only a full FIFO holds the Z stream back
  assign stream_ready_o = (cnt_q != 2'd2);
  assign push           = stream_valid_i && stream_ready_o;
  assign pop            = req_o.req && gnt_i;

  always_comb begin
    req_o      = '0;
    req_o.req  = agen_valid && (cnt_q != 2'd0);
    req_o.addr = agen_addr;
    req_o.wen  = 1'b1;
    req_o.data = fifo_q[rd_ptr_q];
    req_o.be   = '1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      cnt_q <= cnt_q + 2'(push) - 2'(pop);
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= stream_data_i;
    end
  end

  // Address generator stays busy until the last write is granted
  assign busy_o = agen_busy;

endmodule

// ==== rtl/stream_source.sv ====
/* Load stream: address generator, credit-limited reads, response FIFO
   with last flags and the outgoing valid/ready stream */
`timescale 1ns/1ps

module stream_source
  import streamer_pkg::*;
  import tcdm_pkg::*;
#(
  parameter int unsigned LOAD_FIFO_DEPTH = 4
)(
  input  logic              clk_i,
  input  logic              rst_i,
  input  stream_cfg_t       cfg_i,
  output tcdm_req_t         req_o,
  input  logic              gnt_i,
  input  logic              r_valid_i,
  input  logic [DATA_W-1:0] r_data_i,
  output logic              stream_valid_o,
  output logic [DATA_W-1:0] stream_data_o,
  output logic              stream_last_o,
  input  logic              stream_ready_i,
  output logic              busy_o
);

  localparam int unsigned PTR_W = $clog2(LOAD_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(LOAD_FIFO_DEPTH + 1);

  stream_cfg_t       agen_cfg;
  logic [ADDR_W-1:0] agen_addr;
  logic              agen_valid;
  logic              agen_last;
  logic [DATA_W-1:0] fifo_data_q [LOAD_FIFO_DEPTH];
  logic              fifo_last_q [LOAD_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  fifo_cnt_q;
  logic [CNT_W-1:0]  out_cnt_q;
  logic [CNT_W:0]    pending;
  logic              rd_grant;
  logic              rd_last_q;
  logic              pop;
  logic              run_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(LOAD_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // A new run is only accepted once the previous one has drained
  always_comb begin
    agen_cfg       = cfg_i;
    agen_cfg.start = cfg_i.start && !run_q;
  end

  stream_addr_gen i_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .cfg_i    ( agen_cfg   ),
    .addr_o   ( agen_addr  ),
    .valid_o  ( agen_valid ),
    .accept_i ( rd_grant   ),
    .last_o   ( agen_last  ),
    .busy_o   (            )
  );

  // Reads in flight plus stored words never exceed the FIFO depth
  assign pending = {1'b0, out_cnt_q} + {1'b0, fifo_cnt_q};

  always_comb begin
    req_o      = '0;
    req_o.req  = agen_valid && (pending < (CNT_W + 1)'(LOAD_FIFO_DEPTH));
    req_o.addr = agen_addr;
    req_o.wen  = 1'b0;
    req_o.be   = '1;
  end

  assign rd_grant = req_o.req && gnt_i;
  assign pop      = stream_valid_o && stream_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_cnt_q  <= '0;
      fifo_cnt_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      run_q      <= 1'b0;
    end else begin
      out_cnt_q  <= out_cnt_q + CNT_W'(rd_grant) - CNT_W'(r_valid_i);
      fifo_cnt_q <= fifo_cnt_q + CNT_W'(r_valid_i) - CNT_W'(pop);
      if (r_valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (cfg_i.start && !run_q && (cfg_i.count != '0)) begin
        run_q <= 1'b1;
      end else if (pop && stream_last_o) begin
        run_q <= 1'b0;
      end
    end
  end

  // Response comes one cycle after the grant, so one tag register is enough
  always_ff @(posedge clk_i) begin
    if (rd_grant) begin
      rd_last_q <= agen_last;
    end
    if (r_valid_i) begin
      fifo_data_q[wr_ptr_q] <= r_data_i;
      fifo_last_q[wr_ptr_q] <= rd_last_q;
    end
  end

  assign stream_valid_o = (fifo_cnt_q != '0);
  assign stream_data_o  = fifo_data_q[rd_ptr_q];
  assign stream_last_o  = fifo_last_q[rd_ptr_q];
  assign busy_o         = run_q;

endmodule

// ==== rtl/streamer_pkg.sv ====
/* Stream ids, address generator states, per-stream configuration
   and the control and busy flag bundles of the streamer */
package streamer_pkg;

  localparam int unsigned ADDR_W = 32;

  // Stream index, also used to tag grants on the shared port
  typedef enum logic [1:0] {
    SRC_X = 2'd0,
    SRC_W = 2'd1,
    SRC_Y = 2'd2,
    SNK_Z = 2'd3
  } stream_id_e;

  typedef enum logic {
    AGEN_IDLE = 1'b0,
    AGEN_RUN  = 1'b1
  } agen_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [15:0]       stride;  // in bytes
    logic [15:0]       count;   // in words
    logic              start;
  } stream_cfg_t;

  typedef struct packed {
    stream_cfg_t x;
    stream_cfg_t w;
    stream_cfg_t y;
    stream_cfg_t z;
  } streamer_ctrl_t;

  typedef struct packed {
    logic x_busy;
    logic w_busy;
    logic y_busy;
    logic z_busy;
  } streamer_flags_t;

endpackage

// ==== rtl/streamer_top.sv ====
/* Streamer top: three load sources, one store sink, shared port arbiter */
`timescale 1ns/1ps

module streamer_top
  import streamer_pkg::*;
  import tcdm_pkg::*;
#(
  parameter int unsigned LOAD_FIFO_DEPTH = 4
)(
  input  logic              clk_i,
  input  logic              rst_i,
  input  streamer_ctrl_t    ctrl_i,
  output streamer_flags_t   flags_o,
  output tcdm_req_t         tcdm_req_o,
  input  tcdm_rsp_t         tcdm_rsp_i,
  output logic              x_stream_valid_o,
  output logic [DATA_W-1:0] x_stream_data_o,
  output logic              x_stream_last_o,
  input  logic              x_stream_ready_i,
  output logic              w_stream_valid_o,
  output logic [DATA_W-1:0] w_stream_data_o,
  output logic              w_stream_last_o,
  input  logic              w_stream_ready_i,
  output logic              y_stream_valid_o,
  output logic [DATA_W-1:0] y_stream_data_o,
  output logic              y_stream_last_o,
  input  logic              y_stream_ready_i,
  input  logic              z_stream_valid_i,
  input  logic [DATA_W-1:0] z_stream_data_i,
  output logic              z_stream_ready_o
);

  tcdm_req_t [2:0]   src_req;
  tcdm_req_t         snk_req;
  logic [2:0]        src_gnt;
  logic [2:0]        src_r_valid;
  logic              snk_gnt;
  logic [DATA_W-1:0] r_data;

  stream_source #(.LOAD_FIFO_DEPTH(LOAD_FIFO_DEPTH)) i_x_source (
    .clk_i (clk_i), .rst_i (rst_i), .cfg_i (ctrl_i.x),
    .req_o (src_req[SRC_X]), .gnt_i (src_gnt[SRC_X]),
    .r_valid_i (src_r_valid[SRC_X]), .r_data_i (r_data),
    .stream_valid_o (x_stream_valid_o), .stream_data_o (x_stream_data_o),
    .stream_last_o (x_stream_last_o), .stream_ready_i (x_stream_ready_i),
    .busy_o (flags_o.x_busy)
  );

  stream_source #(.LOAD_FIFO_DEPTH(LOAD_FIFO_DEPTH)) i_w_source (
    .clk_i (clk_i), .rst_i (rst_i), .cfg_i (ctrl_i.w),
    .req_o (src_req[SRC_W]), .gnt_i (src_gnt[SRC_W]),
    .r_valid_i (src_r_valid[SRC_W]), .r_data_i (r_data),
    .stream_valid_o (w_stream_valid_o), .stream_data_o (w_stream_data_o),
    .stream_last_o (w_stream_last_o), .stream_ready_i (w_stream_ready_i),
    .busy_o (flags_o.w_busy)
  );

  stream_source #(.LOAD_FIFO_DEPTH(LOAD_FIFO_DEPTH)) i_y_source (
    .clk_i (clk_i), .rst_i (rst_i), .cfg_i (ctrl_i.y),
    .req_o (src_req[SRC_Y]), .gnt_i (src_gnt[SRC_Y]),
    .r_valid_i (src_r_valid[SRC_Y]), .r_data_i (r_data),
    .stream_valid_o (y_stream_valid_o), .stream_data_o (y_stream_data_o),
    .stream_last_o (y_stream_last_o), .stream_ready_i (y_stream_ready_i),
    .busy_o (flags_o.y_busy)
  );

  stream_sink i_z_sink (
    .clk_i (clk_i), .rst_i (rst_i), .cfg_i (ctrl_i.z),
    .stream_valid_i (z_stream_valid_i), .stream_data_i (z_stream_data_i),
    .stream_ready_o (z_stream_ready_o),
    .req_o (snk_req), .gnt_i (snk_gnt), .busy_o (flags_o.z_busy)
  );

  tcdm_port_arbiter i_arbiter (
    .clk_i (clk_i), .rst_i (rst_i),
    .src_req_i (src_req), .snk_req_i (snk_req),
    .src_gnt_o (src_gnt), .snk_gnt_o (snk_gnt),
    .src_r_valid_o (src_r_valid), .r_data_o (r_data),
    .tcdm_req_o (tcdm_req_o), .tcdm_rsp_i (tcdm_rsp_i)
  );

endmodule

// ==== rtl/tcdm_pkg.sv ====
/* Request and response bundles of the shared TCDM memory port */
package tcdm_pkg;

  localparam int unsigned DATA_W = 32;

  // Held by the initiator until gnt is seen
  typedef struct packed {
    logic                req;
    logic [31:0]         addr;
    logic                wen;   // 1 means write
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] be;
  } tcdm_req_t;

  // r_valid follows a read grant by exactly one cycle
  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
  } tcdm_rsp_t;

endpackage

// ==== rtl/tcdm_port_arbiter.sv ====
/* Shared TCDM port arbiter: Z over Y, round-robin among X, W and Y/Z,
   and read response steering by registered id */
`timescale 1ns/1ps

module tcdm_port_arbiter
  import streamer_pkg::*;
  import tcdm_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  tcdm_req_t [2:0]   src_req_i,
  input  tcdm_req_t         snk_req_i,
  output logic [2:0]        src_gnt_o,
  output logic              snk_gnt_o,
  output logic [2:0]        src_r_valid_o,
  output logic [DATA_W-1:0] r_data_o,
  output tcdm_req_t         tcdm_req_o,
  input  tcdm_rsp_t         tcdm_rsp_i
);

  stream_id_e yz_id;
  stream_id_e arb_id;
  stream_id_e cur_id;
  stream_id_e lock_id_q;
  stream_id_e rd_id_q;
  logic [2:0] grp_req;
  logic [1:0] rr_q;
  logic [1:0] win_grp;
  logic [1:0] cur_grp;
  logic       lock_q;
  logic       granted;

  // First stage, Z always beats Y
  assign yz_id   = snk_req_i.req ? SNK_Z : SRC_Y;
  assign grp_req = {snk_req_i.req | src_req_i[SRC_Y].req,
                    src_req_i[SRC_W].req,
                    src_req_i[SRC_X].req};

  // Second stage, first requester at or after the pointer
  always_comb begin
    int unsigned cand;
    win_grp = rr_q;
    for (int k = 2; k >= 0; k--) begin
      cand = rr_q + k;
      if (cand > 2) begin
        cand = cand - 3;
      end
      if (grp_req[cand]) begin
        win_grp = 2'(cand);
      end
    end
  end

  always_comb begin
    case (win_grp)
      2'd0:    arb_id = SRC_X;
      2'd1:    arb_id = SRC_W;
      default: arb_id = yz_id;
    endcase
  end

  // A presented request is held until granted, keeping the port stable
  assign cur_id  = lock_q ? lock_id_q : arb_id;
  assign cur_grp = (cur_id == SNK_Z) ? 2'd2 : 2'(cur_id);

  always_comb begin
    case (cur_id)
      SRC_X:   tcdm_req_o = src_req_i[0];
      SRC_W:   tcdm_req_o = src_req_i[1];
      SRC_Y:   tcdm_req_o = src_req_i[2];
      default: tcdm_req_o = snk_req_i;
    endcase
  end

  assign granted = tcdm_req_o.req && tcdm_rsp_i.gnt;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      src_gnt_o[i]     = granted && (cur_id == stream_id_e'(i));
      src_r_valid_o[i] = tcdm_rsp_i.r_valid && (rd_id_q == stream_id_e'(i));
    end
    snk_gnt_o = granted && (cur_id == SNK_Z);
  end

  assign r_data_o = tcdm_rsp_i.r_data;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q      <= 2'd0;
      lock_q    <= 1'b0;
      lock_id_q <= SRC_X;
      rd_id_q   <= SNK_Z;
    end else begin
      if (granted) begin
        rr_q   <= (cur_grp == 2'd2) ? 2'd0 : cur_grp + 2'd1;
        lock_q <= 1'b0;
        if (!tcdm_req_o.wen) begin
          rd_id_q <= cur_id;
        end
      end else if (tcdm_req_o.req) begin
        lock_q    <= 1'b1;
        lock_id_q <= cur_id;
      end
    end
  end

endmodule

// ==== tests/tb_mem_model.svh ====
/* Memory model for the streamer testbench: word array, random grant,
   one-cycle read return and write capture */

logic [31:0] mem [1024];
logic        rd_pend;
logic [31:0] rd_data;

// Fill mixes the seed with the full word index
task automatic mem_fill();
  for (int i = 0; i < 1024; i++) begin
    mem[i] = $random(seed) ^ (32'(i) << 20) ^ 32'(i);
  end
endtask

// Falling edge: new grant, and read data for a read granted one cycle earlier
task automatic mem_drive();
  tcdm_rsp.gnt     = !rst_i && (($unsigned($random(seed)) % 100) < 60);
  tcdm_rsp.r_valid = rd_pend;
  tcdm_rsp.r_data  = rd_pend ? rd_data : 32'h0;
endtask

// Rising edge: a granted write lands now, a granted read is returned next cycle
task automatic mem_capture();
  rd_pend = 1'b0;
  if (!rst_i && tcdm_req.req && tcdm_rsp.gnt) begin
    if (tcdm_req.wen) begin
      mem[tcdm_req.addr[11:2]] = tcdm_req.data;
    end else begin
      rd_pend = 1'b1;
      rd_data = mem[tcdm_req.addr[11:2]];
    end
  end
endtask

// ==== tests/tb_streamer.sv ====
/* Streamer testbench: clock, reset, random stimulus, load and store
   models, watchdog and closing report */
`timescale 1ns/1ps

module tb_streamer
  import streamer_pkg::*;
  import tcdm_pkg::*;
();

  localparam int MAX_COUNT = 16;
  // Single loads 3, store 1, all four 4, stall run 4
  localparam int NUM_RUNS = 12;
  localparam int WATCHDOG_CYCLES = 200 * NUM_RUNS * MAX_COUNT + 1000;

  logic              clk_i = 1'b0;
  logic              rst_i;
  integer            seed;
  stream_cfg_t       cfg [4];
  stream_cfg_t       next_cfg [4];
  streamer_ctrl_t    ctrl;
  streamer_flags_t   flags;
  tcdm_req_t         tcdm_req;
  tcdm_rsp_t         tcdm_rsp;
  logic [2:0]        s_valid;
  logic [2:0][31:0]  s_data;
  logic [2:0]        s_last;
  logic [2:0]        s_ready;
  logic [2:0]        hold;
  logic              z_valid;
  logic [31:0]       z_data;
  logic              z_ready;
  logic [31:0]       z_words [MAX_COUNT];
  logic [31:0]       shadow [1024];
  logic [3:0]        busy_now;
  int                got [3];
  int                z_idx;
  int                z_total;
  int                wr_cnt;
  int                err_value;
  int                err_other;

  `include "tb_mem_model.svh"

  assign ctrl = {cfg[0], cfg[1], cfg[2], cfg[3]};

  streamer_top #(.LOAD_FIFO_DEPTH(4)) uut (
    .clk_i (clk_i), .rst_i (rst_i), .ctrl_i (ctrl), .flags_o (flags),
    .tcdm_req_o (tcdm_req), .tcdm_rsp_i (tcdm_rsp),
    .x_stream_valid_o (s_valid[0]), .x_stream_data_o (s_data[0]),
    .x_stream_last_o (s_last[0]), .x_stream_ready_i (s_ready[0]),
    .w_stream_valid_o (s_valid[1]), .w_stream_data_o (s_data[1]),
    .w_stream_last_o (s_last[1]), .w_stream_ready_i (s_ready[1]),
    .y_stream_valid_o (s_valid[2]), .y_stream_data_o (s_data[2]),
    .y_stream_last_o (s_last[2]), .y_stream_ready_i (s_ready[2]),
    .z_stream_valid_i (z_valid), .z_stream_data_i (z_data),
    .z_stream_ready_o (z_ready)
  );

  always #4 clk_i = ~clk_i;

  function automatic string stream_tag(input int s);
    case (s)
      0: return "x";
      1: return "w";
      2: return "y";
      default: return "z";
    endcase
  endfunction

  // Busy bits indexed by stream number, X in bit 0
  function automatic logic [3:0] busy_bits();
    return {flags.z_busy, flags.y_busy, flags.w_busy, flags.x_busy};
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] want,
                                 input logic [31:0] act);
    $display("ERR t=%0t %s expected %h actual %h", $time, sig, want, act);
    err_value++;
  endtask

  task automatic check_beat(input int s);
    logic [31:0] addr;
    logic [31:0] want;
    if (got[s] >= int'(cfg[s].count)) begin
      $display("%0t: %s stream delivered a beat past its word count", $time, stream_tag(s));
      err_other++;
    end else begin
      addr = cfg[s].base + 32'(got[s]) * 32'(cfg[s].stride);
      want = shadow[addr[11:2]];
      if (s_data[s] !== want) begin
        report_mismatch($sformatf("%s_stream_data_o", stream_tag(s)), want, s_data[s]);
      end
      if (s_last[s] !== (got[s] == int'(cfg[s].count) - 1)) begin
        report_mismatch($sformatf("%s_stream_last_o", stream_tag(s)),
                        32'(got[s] == int'(cfg[s].count) - 1), 32'(s_last[s]));
      end
    end
    got[s]++;
  endtask

  task automatic check_write();
    logic [31:0] want_addr;
    if (wr_cnt >= z_total) begin
      $display("%0t: write to %h with no Z beat left to store", $time, tcdm_req.addr);
      err_other++;
    end else begin
      want_addr = cfg[3].base + 32'(wr_cnt) * 32'(cfg[3].stride);
      if (tcdm_req.addr !== want_addr) begin
        report_mismatch("tcdm_req_o.addr", want_addr, tcdm_req.addr);
      end
      if (tcdm_req.data !== z_words[wr_cnt]) begin
        report_mismatch("tcdm_req_o.data", z_words[wr_cnt], tcdm_req.data);
      end
      if (tcdm_req.be !== 4'hf) begin
        report_mismatch("tcdm_req_o.be", 32'hf, 32'(tcdm_req.be));
      end
    end
    wr_cnt++;
  endtask

  // Beats, writes and memory are sampled at the rising edge
  always @(posedge clk_i) begin
    if (!rst_i) begin
      for (int s = 0; s < 3; s++) begin
        if (s_valid[s] && s_ready[s]) begin
          check_beat(s);
        end
      end
      if (z_valid && z_ready) begin
        z_idx++;
      end
      if (tcdm_req.req && tcdm_rsp.gnt && tcdm_req.wen) begin
        check_write();
      end
    end
    mem_capture();
  end

  // All per-cycle inputs change on the falling edge
  always @(negedge clk_i) begin
    mem_drive();
    for (int s = 0; s < 3; s++) begin
      s_ready[s] = !hold[s] && (($unsigned($random(seed)) % 100) < 70);
    end
    z_valid = (z_idx < z_total);
    z_data  = z_valid ? z_words[z_idx] : 32'h0;
  end

  // Loads use words s*256 onwards, the store region starts at word 768
  task automatic pick_config(input int s);
    logic [31:0] word;
    logic [31:0] addr;
    word = 32'(s) * 256 + ($unsigned($random(seed)) % 128);
    next_cfg[s].base   = word << 2;
    next_cfg[s].stride = 16'(($unsigned($random(seed)) % 8) * 4);
    next_cfg[s].count  = 16'(1 + ($unsigned($random(seed)) % MAX_COUNT));
    next_cfg[s].start  = 1'b0;
    if (s == 3) begin
      for (int i = 0; i < int'(next_cfg[s].count); i++) begin
        z_words[i] = $random(seed);
        addr = next_cfg[s].base + 32'(i) * 32'(next_cfg[s].stride);
        shadow[addr[11:2]] = z_words[i];
      end
    end
  endtask

  task automatic launch(input logic [3:0] mask);
    if (mask[3]) begin
      wr_cnt  = 0;
      z_idx   = 0;
      z_total = int'(next_cfg[3].count);
    end
    @(negedge clk_i);
    for (int s = 0; s < 4; s++) begin
      if (mask[s]) begin
        cfg[s] = next_cfg[s];
        cfg[s].start = 1'b1;
        if (s < 3) begin
          got[s] = 0;
        end
      end
    end
    @(negedge clk_i);
    for (int s = 0; s < 4; s++) begin
      cfg[s].start = 1'b0;
    end
  endtask

  task automatic wait_done(input logic [3:0] mask);
    @(negedge clk_i);
    while (((busy_bits() & mask) != 4'b0) || (mask[3] && (z_idx < z_total))) begin
      @(negedge clk_i);
    end
  endtask

  task automatic check_run(input logic [3:0] mask);
    for (int s = 0; s < 3; s++) begin
      if (mask[s] && (got[s] != int'(cfg[s].count))) begin
        $display("%0t: %s stream delivered %0d beats instead of %0d",
                 $time, stream_tag(s), got[s], cfg[s].count);
        err_other++;
      end
    end
    if (mask[3] && (wr_cnt != z_total)) begin
      $display("%0t: store stream made %0d writes instead of %0d", $time, wr_cnt, z_total);
      err_other++;
    end
    if (flags !== 4'b0) begin
      report_mismatch("flags_o", 32'h0, 32'(flags));
    end
    for (int i = 0; i < 1024; i++) begin
      if (mem[i] !== shadow[i]) begin
        report_mismatch($sformatf("mem[%0d]", i), shadow[i], mem[i]);
      end
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles with streams still running",
             WATCHDOG_CYCLES);
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    $display("Test failed");
    $finish;
  end

  initial begin
    seed      = 32'hb462;
    err_value = 0;
    err_other = 0;
    rst_i     = 1'b1;
    hold      = 3'b0;
    s_ready   = 3'b0;
    z_valid   = 1'b0;
    z_data    = 32'h0;
    z_idx     = 0;
    z_total   = 0;
    wr_cnt    = 0;
    rd_pend   = 1'b0;
    rd_data   = 32'h0;
    tcdm_rsp  = '0;
    for (int s = 0; s < 4; s++) begin
      cfg[s] = '0;
    end
    for (int s = 0; s < 3; s++) begin
      got[s] = 0;
    end
    mem_fill();
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = mem[i];
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Idle outputs after reset
    if (flags !== 4'b0) begin
      report_mismatch("flags_o", 32'h0, 32'(flags));
    end
    if (s_valid !== 3'b0) begin
      report_mismatch("stream valids", 32'h0, 32'(s_valid));
    end
    if (tcdm_req.req !== 1'b0) begin
      report_mismatch("tcdm_req_o.req", 32'h0, 32'(tcdm_req.req));
    end

    // One load stream at a time
    for (int s = 0; s < 3; s++) begin
      @(posedge clk_i);
      pick_config(s);
      launch(4'b1 << s);
      wait_done(4'b1 << s);
      check_run(4'b1 << s);
    end

    // Store stream alone
    @(posedge clk_i);
    pick_config(3);
    launch(4'b1000);
    wait_done(4'b1000);
    check_run(4'b1000);

    // All four streams together
    @(posedge clk_i);
    for (int s = 0; s < 4; s++) begin
      pick_config(s);
    end
    launch(4'b1111);
    wait_done(4'b1111);
    check_run(4'b1111);

    // W ready held low while the others run to completion
    @(posedge clk_i);
    for (int s = 0; s < 4; s++) begin
      pick_config(s);
    end
    hold[1] = 1'b1;
    launch(4'b1111);
    wait_done(4'b1101);
    busy_now = busy_bits();
    if ((busy_now[1] !== 1'b1) || (s_valid[1] !== 1'b1)) begin
      $display("%0t: w stream finished or held no data while its ready was held low",
               $time);
      err_other++;
    end
    @(posedge clk_i);
    hold[1] = 1'b0;
    wait_done(4'b0010);
    check_run(4'b1111);

    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if ((err_value + err_other) == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
